// File: logic/dcache_consts.svh
/*
 * data cache constants
 * widths, line count and main memory read latency
 */
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// --------------------------------------------------
// address and data geometry
// --------------------------------------------------
`define DC_ADDR_W      12  // word address, 4096 words of backing store
`define DC_INDEX_W     6   // line index, 64 lines
`define DC_TAG_W       6   // what is left of the address above the index
`define DC_WORD_W      32  // one word per line

// --------------------------------------------------
// main memory timing
// --------------------------------------------------
`define DC_MEM_LATENCY 4   // cycles from read start to data valid

`endif

// File: logic/dcache_pkg.sv
/*
 * data cache package
 * address, index, tag and word types shared by the cache blocks
 */
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

  // full word address as seen by the requester
  typedef logic [`DC_ADDR_W-1:0]  addr_t;

  // low part of the address picks the line
  typedef logic [`DC_INDEX_W-1:0] index_t;

  // high part is stored per line and compared on lookup
  typedef logic [`DC_TAG_W-1:0]   tag_t;

  typedef logic [`DC_WORD_W-1:0]  word_t;  // data payload

endpackage

`default_nettype wire

// File: logic/cache_ram.sv
/*
 * cache line storage
 * one entry per line, clocked write, combinational read
 */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module cache_ram import dcache_pkg::*; #(
  parameter type payload_t = word_t  // tag_t or word_t
) (
  input  logic     clk,
  input  logic     we,
  input  index_t   windex,
  input  payload_t wdata,
  input  index_t   rindex,
  output payload_t rdata
);

  localparam int lines = 1 << `DC_INDEX_W;

  payload_t mem [lines];  // entries count only while the line's valid bit is set

  always_ff @(posedge clk) begin
    if (we) mem[windex] <= wdata;
  end

  assign rdata = mem[rindex];  // same cycle read

  // an X index would corrupt a random line and leave its valid bit stale
  a_windex_known: assert property (@(posedge clk) we |-> !$isunknown(windex))
    else $error("cache_ram write with unknown index");

endmodule

`default_nettype wire

// File: logic/dcache_array.sv
/*
 * direct mapped cache array
 * valid bits, tag store and data store with the hit compare
 */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_array import dcache_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  we,     // fill or write hit
  input  addr_t addr,
  input  word_t wdata,
  output logic  hit,
  output word_t rdata
);

  localparam int lines = 1 << `DC_INDEX_W;

  index_t           index;
  tag_t             tag;
  tag_t             stored_tag;
  logic [lines-1:0] valid_q;

  // --------------------------------------------------
  // address split
  // --------------------------------------------------
  assign index = addr[`DC_INDEX_W-1:0];            // low bits pick the line
  assign tag   = addr[`DC_ADDR_W-1:`DC_INDEX_W];   // high bits identify it

  // valid bits, cleared by reset so a cold cache never hits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (we) begin
      valid_q[index] <= 1'b1;  // any write leaves the line valid
    end
  end

  // --------------------------------------------------
  // tag and data stores
  // --------------------------------------------------
  cache_ram #(
    .payload_t (tag_t)
  ) tag_store (
    .clk    (clk),
    .we     (we),
    .windex (index),
    .wdata  (tag),         // tag comes from the same address
    .rindex (index),
    .rdata  (stored_tag)
  );

  cache_ram #(
    .payload_t (word_t)
  ) data_store (
    .clk    (clk),
    .we     (we),
    .windex (index),
    .wdata  (wdata),
    .rindex (index),
    .rdata  (rdata)        // straight out, top decides when it is used
  );

  // line must be valid and hold the requested tag
  assign hit = valid_q[index] & (stored_tag == tag);

endmodule

`default_nettype wire

// File: logic/refill_timer.sv
/*
 * refill timer
 * counts the main memory latency and strobes done when the word is ready
 */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module refill_timer import dcache_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic load,   // read started
  output logic done    // one cycle, DC_MEM_LATENCY cycles after load
);

  localparam int cnt_w = $clog2(`DC_MEM_LATENCY + 1);

  logic [cnt_w-1:0] cnt_q;  // zero when idle

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (load) begin
      cnt_q <= cnt_w'(`DC_MEM_LATENCY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;  // count down to idle
    end
  end

  // last count cycle, so done lands exactly latency cycles after load
  assign done = (cnt_q == cnt_w'(1));

  // only one read in flight, a reload would silently drop the first
  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    load |-> cnt_q == '0)
    else $error("refill_timer loaded while running");

endmodule

`default_nettype wire

// File: logic/main_memory.sv
/*
 * main memory model
 * word wide backing store, writes on the edge, reads after a fixed latency
 */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module main_memory import dcache_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  we,
  input  addr_t addr,
  input  word_t wdata,
  input  logic  rd_start,  // begin a timed read of addr
  output word_t rdata,
  output logic  rd_valid   // rdata good for this cycle only
);

  localparam int words = 1 << `DC_ADDR_W;

  word_t mem [words];  // undefined until written
  addr_t rd_addr_q;    // address of the read in flight

  // --------------------------------------------------
  // write port and read address capture
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (we) mem[addr] <= wdata;
  end

  always_ff @(posedge clk) begin
    if (rd_start) rd_addr_q <= addr;
  end

  // --------------------------------------------------
  // read latency
  // --------------------------------------------------
  refill_timer timer (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (rd_start),
    .done  (rd_valid)   // timer strobe doubles as data valid
  );

  // word is looked up at the end of the wait, so a write during the wait shows
  assign rdata = mem[rd_addr_q];

endmodule

`default_nettype wire

// File: logic/dcache_ctrl.sv
/*
 * data cache controller
 * sequences lookup, memory wait, fill and response
 */
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic req,
  input  logic we,            // latched request type
  input  logic hit,
  input  logic mem_rd_valid,
  output logic mem_rd_start,
  output logic mem_we,
  output logic fill_we,
  output logic wr_hit_we,
  output logic resp_valid,
  output logic resp_hit
);

  typedef enum logic [1:0] {IDLE, LOOKUP, MEM_WAIT, FILL} state_t;

  state_t state_q, state_d;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state_q <= IDLE;
    else        state_q <= state_d;
  end

  // --------------------------------------------------
  // next state and strobes
  // --------------------------------------------------
  always_comb begin
    state_d      = state_q;
    mem_rd_start = 1'b0;
    mem_we       = 1'b0;
    fill_we      = 1'b0;
    wr_hit_we    = 1'b0;
    resp_valid   = 1'b0;
    resp_hit     = 1'b0;
    case (state_q)
      IDLE: begin
        if (req) state_d = LOOKUP;  // request latched on this edge
      end
      LOOKUP: begin
        if (we) begin
          mem_we     = 1'b1;  // write through, always
          wr_hit_we  = hit;   // no allocate on a miss
          resp_valid = 1'b1;
          resp_hit   = hit;
          state_d    = IDLE;
        end else if (hit) begin
          resp_valid = 1'b1;
          resp_hit   = 1'b1;
          state_d    = IDLE;
        end else begin
          mem_rd_start = 1'b1;  // read miss, go to memory
          state_d      = MEM_WAIT;
        end
      end
      MEM_WAIT: begin
        if (mem_rd_valid) begin
          fill_we = 1'b1;  // line written on the edge into FILL
          state_d = FILL;
        end
      end
      FILL: begin
        resp_valid = 1'b1;  // answer with the fetched word, reported as miss
        state_d    = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  a_resp_single: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid |=> !resp_valid)
    else $error("resp_valid held for two cycles");

  // requester must wait for the response, there is no back pressure
  a_req_idle: assert property (@(posedge clk) disable iff (!rst_n)
    req |-> state_q == IDLE)
    else $error("request arrived while the cache was busy");

endmodule

`default_nettype wire

// File: logic/dcache_top.sv
/*
 * data cache top level
 * latches the request, muxes write data and joins controller, array and memory
 */
`timescale 1ns/10ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  req,
  input  logic  we,
  input  addr_t addr,
  input  word_t wdata,
  output logic  resp_valid,
  output logic  resp_hit,
  output word_t rdata
);

  logic  we_q;
  addr_t addr_q;
  word_t wdata_q;
  logic  hit;
  logic  mem_rd_start, mem_rd_valid, mem_we;
  logic  fill_we, wr_hit_we;
  word_t array_wdata, array_rdata;
  word_t mem_rdata;
  word_t fill_word_q;  // fetched word kept for the miss response

  // --------------------------------------------------
  // request latch, held until the next req
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (req) begin
      we_q    <= we;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_rd_valid) fill_word_q <= mem_rdata;
  end

  dcache_ctrl ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .we           (we_q),
    .hit          (hit),
    .mem_rd_valid (mem_rd_valid),
    .mem_rd_start (mem_rd_start),
    .mem_we       (mem_we),
    .fill_we      (fill_we),
    .wr_hit_we    (wr_hit_we),
    .resp_valid   (resp_valid),
    .resp_hit     (resp_hit)
  );

  // fill takes the memory word, a write hit takes the request data
  assign array_wdata = fill_we ? mem_rdata : wdata_q;

  dcache_array array (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (fill_we | wr_hit_we),
    .addr  (addr_q),
    .wdata (array_wdata),
    .hit   (hit),
    .rdata (array_rdata)
  );

  main_memory memory (
    .clk      (clk),
    .rst_n    (rst_n),
    .we       (mem_we),
    .addr     (addr_q),
    .wdata    (wdata_q),
    .rd_start (mem_rd_start),
    .rdata    (mem_rdata),
    .rd_valid (mem_rd_valid)
  );

  // hit answers from the array, a miss from the registered fetch
  assign rdata = resp_hit ? array_rdata : fill_word_q;

endmodule

`default_nettype wire

// File: verif/dcache_tb.sv
/*
 * data cache testbench
 * directed and LFSR requests against a shadow model of the cache and memory
 */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_tb import dcache_pkg::*; ();

  localparam int fill_words  = 256;  // region written first, also the random range
  localparam int cold_reads  = 64;
  localparam int random_ops  = 300;
  localparam int n_ops       = fill_words + cold_reads + 8 + 4 + 3 + random_ops;
  localparam int cycle_limit = n_ops * (`DC_MEM_LATENCY + 4) + 100;
  localparam int lines       = 1 << `DC_INDEX_W;

  logic  clk;
  logic  rst_n;
  logic  req;
  logic  we;
  addr_t addr;
  word_t wdata;
  logic  resp_valid;
  logic  resp_hit;
  word_t rdata;

  // shadow state of the model
  word_t ref_mem [1 << `DC_ADDR_W];
  logic  ref_valid [lines];
  tag_t  ref_tag [lines];

  // expectation of the one request in flight
  logic  pending;
  logic  exp_we;
  logic  exp_hit;
  word_t exp_data;
  int    exp_lat;
  addr_t exp_addr;
  int    req_cycle;
  logic  last_hit;

  int          cycle;
  int          errors;
  logic [15:0] lfsr;

  dcache_top dcache_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .we         (we),
    .addr       (addr),
    .wdata      (wdata),
    .resp_valid (resp_valid),
    .resp_hit   (resp_hit),
    .rdata      (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // write-through, no allocate; a read miss fills the line
  function automatic void model_access(input logic w, input addr_t a, input word_t d,
                                       output logic hit_e, output word_t data_e,
                                       output int lat_e);
    index_t idx;
    tag_t   tg;
    idx   = a[`DC_INDEX_W-1:0];
    tg    = a[`DC_ADDR_W-1:`DC_INDEX_W];
    hit_e = ref_valid[idx] && (ref_tag[idx] == tg);
    if (w) begin
      ref_mem[a] = d;  // memory always written, cache copy follows on a hit
      data_e     = d;
      lat_e      = 1;
    end else begin
      data_e = ref_mem[a];  // a valid line always mirrors memory
      if (hit_e) begin
        lat_e = 1;
      end else begin
        lat_e          = `DC_MEM_LATENCY + 2;
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tg;
      end
    end
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] time %0t: %s at addr %h, got %h expected %h",
               $time, what, exp_addr, got, exp);
      errors++;
    end
  endtask

  // one request, then wait for its answer
  task automatic issue_request(input logic w, input addr_t a, input word_t d);
    logic  h;
    word_t x;
    int    l;
    model_access(w, a, d, h, x, l);
    @(posedge clk);
    exp_we   = w;
    exp_hit  = h;
    exp_data = x;
    exp_lat  = l;
    exp_addr = a;
    pending  = 1'b1;
    req     <= 1'b1;
    we      <= w;
    addr    <= a;
    wdata   <= d;
    @(posedge clk);
    req <= 1'b0;
    wait (pending == 1'b0);  // compare process clears it
  endtask

  // --------------------------------------------------
  // compare process, samples mid cycle
  // --------------------------------------------------
  always @(negedge clk) begin
    if (rst_n) begin
      if (req) req_cycle = cycle;  // edge ending this cycle samples req
      if (resp_valid) begin
        if (!pending) begin
          $display("resp_valid seen with no request outstanding at time %0t", $time);
          errors++;
        end else begin
          check_value("hit flag", resp_hit, exp_hit);
          if (!exp_we) check_value("read data", rdata, exp_data);
          check_value("latency", cycle - req_cycle, exp_lat);
          last_hit = resp_hit;
          pending  = 1'b0;
        end
      end else if (pending && (cycle - req_cycle > `DC_MEM_LATENCY + 4)) begin
        $display("no response for the request to address %h at time %0t", exp_addr, $time);
        errors++;
        pending = 1'b0;  // move on
      end
    end
  end

  always @(posedge clk) cycle <= cycle + 1;

  // run limit from the op count
  always @(posedge clk) begin
    if (cycle >= cycle_limit) begin
      $display("run stopped after %0d cycles, the cache stopped answering", cycle);
      $display("errors: %0d", errors);
      $display("TEST FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    wdata     = '0;
    rst_n     = 1'b0;
    pending   = 1'b0;
    errors    = 0;
    cycle     = 0;
    req_cycle = 0;
    last_hit  = 1'b0;
    lfsr      = 16'd53;
    for (int i = 0; i < lines; i++) ref_valid[i] = 1'b0;  // cold cache
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // cold misses over a written region
    for (int i = 0; i < fill_words; i++) issue_request(1'b1, addr_t'(i), rand_bits(32));
    for (int i = 0; i < cold_reads; i++) begin
      issue_request(1'b0, addr_t'(i), '0);
      check_value("cold read hit flag", last_hit, 1'b0);
    end

    // repeated reads hit
    for (int i = 0; i < 8; i++) issue_request(1'b0, addr_t'(i), '0);

    // write hit updates the line, write miss leaves it alone
    issue_request(1'b1, 12'h003, rand_bits(32));
    issue_request(1'b0, 12'h003, '0);
    issue_request(1'b1, 12'h083, rand_bits(32));  // tag 2 on line 3
    issue_request(1'b0, 12'h083, '0);

    // same index, two tags
    issue_request(1'b0, 12'h010, '0);
    issue_request(1'b0, 12'h050, '0);
    issue_request(1'b0, 12'h010, '0);
    check_value("evicted line hit flag", last_hit, 1'b0);

    // random mix, 256 addresses over 64 lines
    for (int i = 0; i < random_ops; i++) begin
      if (rand_bits(2) == 0) issue_request(1'b1, addr_t'(rand_bits(8)), rand_bits(32));
      else                   issue_request(1'b0, addr_t'(rand_bits(8)), '0);
    end

    repeat (4) @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/dcache_pkg.sv
logic/cache_ram.sv
logic/dcache_array.sv
logic/refill_timer.sv
logic/main_memory.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verif/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

export_include_dirs:
  - logic

sources:
  - files:
      - logic/dcache_pkg.sv
      - logic/cache_ram.sv
      - logic/dcache_array.sv
      - logic/refill_timer.sv
      - logic/main_memory.sv
      - logic/dcache_ctrl.sv
      - logic/dcache_top.sv
  - target: test
    files:
      - verif/dcache_tb.sv
